/* design/zport_pkg.sv */
// zport package: port map, extended register indices, reset values and the #7FFD view
package zport_pkg;

	// low address byte of each port
	localparam logic [7:0] PORT_FE   = 8'hFE;	// keyboard, tape, beeper
	localparam logic [7:0] PORT_FD   = 8'hFD;	// #7FFD when a15 is low
	localparam logic [7:0] PORT_XT   = 8'hAF;	// extended window #xxAF
	localparam logic [7:0] PORT_KJOY = 8'h1F;	// kempston joystick

	// extended register index, high address byte
	localparam logic [7:0] XT_STAT    = 8'h00;
	localparam logic [7:0] XT_RAMPAGE = 8'h10;	// #10..#13 page group
	localparam logic [7:0] XT_FMADDR  = 8'h15;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;
	localparam logic [7:0] XT_INTMASK = 8'h2A;

	// im2 source codes, data bits 6:4 of a #25 write
	localparam logic [2:0] INT_FRM = 3'b000;
	localparam logic [2:0] INT_LIN = 3'b001;
	localparam logic [2:0] INT_DMA = 3'b010;

	localparam logic [7:0]  SYSCONF_RST = 8'h01;	// turbo 7 MHz
	localparam logic [7:0]  MEMCONF_RST = 8'h04;	// rom map off
	localparam logic [7:0]  INTMASK_RST = 8'h01;	// frame int only
	localparam logic [2:0]  IM2V_RST    = 3'b111;
	localparam logic [31:0] RAMPAGE_RST = 32'h00020500;	// {page3, page2, page1, page0}

	// bit positions in a port_sel_t word
	localparam int SEL_FE   = 0;
	localparam int SEL_FD   = 1;
	localparam int SEL_XT   = 2;
	localparam int SEL_KJOY = 3;
	localparam int SEL_HIT  = 4;	// any known port

	typedef logic [4:0] port_sel_t;

	// #7FFD data, as a byte or as paging fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] page_hi;	// 7:6
			logic       ext;		// lock48, or page bit 5 in mode 3
			logic       rom;
			logic       scr;
			logic [2:0] page_lo;
		} f;
	} p7ffd_u;

endpackage

/* design/port_decode.sv */
// port decode stage: registers an I/O request with its port selects
`timescale 1ns/1ns

module port_decode import zport_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        req_valid,
	input  logic [15:0] req_addr,
	input  logic [7:0]  req_data,
	input  logic        req_rnw,
	output logic        req_ready,

	output logic        dec_valid,
	output logic [15:0] dec_addr,
	output logic [7:0]  dec_data,
	output logic        dec_rnw,
	output port_sel_t   dec_sel,
	input  logic        dec_ready
);

	logic [7:0] loa;
	port_sel_t  sel;
	logic       take;

	assign loa = req_addr[7:0];

	// port selects from low byte, a15 splits #7FFD from the AY ports
	always_comb
	begin
		sel = '0;
		sel[SEL_FE]   = (loa == PORT_FE);
		sel[SEL_FD]   = (loa == PORT_FD) && !req_addr[15];
		sel[SEL_XT]   = (loa == PORT_XT);
		sel[SEL_KJOY] = (loa == PORT_KJOY);
		sel[SEL_HIT]  = sel[SEL_FE] | sel[SEL_FD] | sel[SEL_XT] | sel[SEL_KJOY];
	end

	// stage free or draining this cycle
	assign req_ready = !dec_valid || dec_ready;
	assign take = req_valid && req_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
			dec_valid <= 1'b0;
		else if (req_ready)
			dec_valid <= req_valid;
	end

	// payload held while stalled
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			dec_addr <= req_addr;
			dec_data <= req_data;
			dec_rnw  <= req_rnw;
			dec_sel  <= sel;
		end
	end

endmodule

/* design/mem_paging.sv */
// memory paging: RAM page registers, memconf and #7FFD lock handling
`timescale 1ns/1ns

module mem_paging import zport_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        exec_wr,
	input  logic [15:0] dec_addr,
	input  logic [7:0]  dec_data,
	input  port_sel_t   dec_sel,

	input  logic        opfetch,
	input  logic [7:0]  fetch_data,

	output logic [31:0] xt_page,
	output logic [7:0]  memconf,
	output logic [7:0]  page2,
	output logic [7:0]  page3
);

	logic [7:0] rampage [0:3];
	logic       lock48;
	logic       fetch_lock;	// mode 2 lock from last opcode
	logic       mode2;
	logic       mode3;
	logic       lock128;
	logic       xt_wr;
	logic       fd_wr;
	logic [7:0] page3_nxt;
	p7ffd_u     p7;

	assign p7.raw = dec_data;

	assign mode2 = (memconf[7:6] == 2'b10);
	assign mode3 = (memconf[7:6] == 2'b11);
	assign lock128 = mode2 ? fetch_lock : memconf[6];

	assign xt_wr = exec_wr && dec_sel[SEL_XT];
	assign fd_wr = exec_wr && dec_sel[SEL_FD] && !lock48;	// frozen in 48k lock

	// mode 3 gives 1M via bit 5, other modes up to 512k unless locked
	always_comb
	begin
		if (mode3)
			page3_nxt = {2'b00, p7.f.ext, p7.f.page_hi, p7.f.page_lo};
		else
			page3_nxt = {3'b000, lock128 ? 2'b00 : p7.f.page_hi, p7.f.page_lo};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage[0] <= RAMPAGE_RST[7:0];
			rampage[1] <= RAMPAGE_RST[15:8];
			rampage[2] <= RAMPAGE_RST[23:16];
			rampage[3] <= RAMPAGE_RST[31:24];
			memconf    <= MEMCONF_RST;
			lock48     <= 1'b0;
		end
		else if (fd_wr)
		begin
			memconf[0] <= p7.f.rom;
			rampage[3] <= page3_nxt;
			if (!mode3)
				lock48 <= p7.f.ext;
		end
		else if (xt_wr)
		begin
			if (dec_addr[15:10] == XT_RAMPAGE[7:2])
				rampage[dec_addr[9:8]] <= dec_data;
			if (dec_addr[15:8] == XT_MEMCONF)
				memconf <= dec_data;
		end
	end

	// snoop of M1 cycles, opcodes #40..#BF unlock
	always_ff @(posedge clk)
	begin
		if (rst)
			fetch_lock <= 1'b0;
		else if (opfetch)
			fetch_lock <= !(fetch_data[7] ^ fetch_data[6]);
	end

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};
	assign page2 = rampage[2];
	assign page3 = rampage[3];

endmodule

/* design/sys_regs.sv */
// system registers: sysconf, font address, IM2 vectors, interrupt mask, power-up flag
`timescale 1ns/1ns

module sys_regs import zport_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        exec_wr,
	input  logic        dec_valid,
	input  logic        dec_ready,
	input  logic        dec_rnw,
	input  logic [15:0] dec_addr,
	input  logic [7:0]  dec_data,
	input  port_sel_t   dec_sel,

	output logic [7:0]  sysconf,
	output logic [7:0]  intmask,
	output logic [4:0]  fmaddr,
	output logic [2:0]  im2v_frm,
	output logic [2:0]  im2v_lin,
	output logic [2:0]  im2v_dma,
	output logic        pwr_up
);

	logic [7:0] hoa;
	logic       xt_wr;
	logic       stat_rd;

	assign hoa = dec_addr[15:8];
	assign xt_wr = exec_wr && dec_sel[SEL_XT];

	// status read moving into the response register
	assign stat_rd = dec_valid && dec_ready && dec_rnw && dec_sel[SEL_XT] && (hoa == XT_STAT);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sysconf  <= SYSCONF_RST;
			intmask  <= INTMASK_RST;
			fmaddr   <= 5'd0;	// font remap off
			im2v_frm <= IM2V_RST;
			im2v_lin <= IM2V_RST;
			im2v_dma <= IM2V_RST;
		end
		else if (xt_wr)
		begin
			if (hoa == XT_SYSCONF)
				sysconf <= dec_data;
			if (hoa == XT_INTMASK)
				intmask <= dec_data;
			if (hoa == XT_FMADDR)
				fmaddr <= dec_data[4:0];
			// one vector per write, source in 6:4
			if (hoa == XT_IM2VECT)
			begin
				if (dec_data[6:4] == INT_FRM)
					im2v_frm <= dec_data[3:1];
				if (dec_data[6:4] == INT_LIN)
					im2v_lin <= dec_data[3:1];
				if (dec_data[6:4] == INT_DMA)
					im2v_dma <= dec_data[3:1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (stat_rd)
			pwr_up <= 1'b0;	// first status read still sees 1
	end

endmodule

/* design/port_respond.sv */
// response stage: executes a decoded request and holds the response until taken
`timescale 1ns/1ns

module port_respond import zport_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        dec_valid,
	input  logic [15:0] dec_addr,
	input  logic [7:0]  dec_data,
	input  logic        dec_rnw,
	input  port_sel_t   dec_sel,
	output logic        dec_ready,
	output logic        exec_wr,

	input  logic [4:0]  keys_in,
	input  logic        tape_in,
	input  logic [4:0]  kj_in,
	input  logic        pwr_up,
	input  logic [7:0]  page2,
	input  logic [7:0]  page3,

	output logic        rsp_valid,
	output logic [7:0]  rsp_data,
	output logic        rsp_hit,
	input  logic        rsp_ready
);

	logic       load;
	logic [7:0] rd_data;

	assign dec_ready = !rsp_valid || rsp_ready;
	assign load = dec_valid && dec_ready;
	assign exec_wr = load && !dec_rnw;	// register blocks update on this edge

	always_comb
	begin
		rd_data = 8'hFF;
		if (dec_sel[SEL_FE])
			rd_data = {1'b1, tape_in, 1'b0, keys_in};
		else if (dec_sel[SEL_KJOY])
			rd_data = {3'b000, kj_in};
		else if (dec_sel[SEL_XT])
		begin
			case (dec_addr[15:8])
				XT_STAT:            rd_data = {1'b0, pwr_up, 6'b000000};
				XT_RAMPAGE + 8'd2:  rd_data = page2;
				XT_RAMPAGE + 8'd3:  rd_data = page3;
				default:            rd_data = 8'hFF;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rsp_valid <= 1'b0;
		else if (dec_ready)
			rsp_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			rsp_data <= dec_rnw ? rd_data : 8'hFF;	// writes answered with bus idle value
			rsp_hit  <= dec_sel[SEL_HIT];
		end
	end

endmodule

/* design/zport_top.sv */
// zport top: request decode, register blocks and response stage of the Z80 I/O ports
`timescale 1ns/1ns

module zport_top import zport_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic        req_valid,
	input  logic [15:0] req_addr,
	input  logic [7:0]  req_data,
	input  logic        req_rnw,
	output logic        req_ready,

	output logic        rsp_valid,
	output logic [7:0]  rsp_data,
	output logic        rsp_hit,
	input  logic        rsp_ready,

	input  logic        opfetch,
	input  logic [7:0]  fetch_data,
	input  logic [4:0]  keys_in,
	input  logic        tape_in,
	input  logic [4:0]  kj_in,

	output logic [31:0] xt_page,
	output logic [7:0]  memconf,
	output logic [7:0]  sysconf,
	output logic [7:0]  intmask,
	output logic [4:0]  fmaddr,
	output logic [2:0]  im2v_frm,
	output logic [2:0]  im2v_lin,
	output logic [2:0]  im2v_dma
);

	logic        dec_valid;
	logic [15:0] dec_addr;
	logic [7:0]  dec_data;
	logic        dec_rnw;
	port_sel_t   dec_sel;
	logic        dec_ready;
	logic        exec_wr;
	logic        pwr_up;
	logic [7:0]  page2;
	logic [7:0]  page3;

	port_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.req_data  (req_data),
		.req_rnw   (req_rnw),
		.req_ready (req_ready),
		.dec_valid (dec_valid),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data),
		.dec_rnw   (dec_rnw),
		.dec_sel   (dec_sel),
		.dec_ready (dec_ready)
	);

	mem_paging u_paging (
		.clk        (clk),
		.rst        (rst),
		.exec_wr    (exec_wr),
		.dec_addr   (dec_addr),
		.dec_data   (dec_data),
		.dec_sel    (dec_sel),
		.opfetch    (opfetch),
		.fetch_data (fetch_data),
		.xt_page    (xt_page),
		.memconf    (memconf),
		.page2      (page2),
		.page3      (page3)
	);

	sys_regs u_sys (
		.clk       (clk),
		.rst       (rst),
		.exec_wr   (exec_wr),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec_rnw   (dec_rnw),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data),
		.dec_sel   (dec_sel),
		.sysconf   (sysconf),
		.intmask   (intmask),
		.fmaddr    (fmaddr),
		.im2v_frm  (im2v_frm),
		.im2v_lin  (im2v_lin),
		.im2v_dma  (im2v_dma),
		.pwr_up    (pwr_up)
	);

	port_respond u_respond (
		.clk       (clk),
		.rst       (rst),
		.dec_valid (dec_valid),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data),
		.dec_rnw   (dec_rnw),
		.dec_sel   (dec_sel),
		.dec_ready (dec_ready),
		.exec_wr   (exec_wr),
		.keys_in   (keys_in),
		.tape_in   (tape_in),
		.kj_in     (kj_in),
		.pwr_up    (pwr_up),
		.page2     (page2),
		.page3     (page3),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_hit   (rsp_hit),
		.rsp_ready (rsp_ready)
	);

endmodule

/* tests/tb_zport.sv */
// zport testbench: pipelined port requests checked against a reference model
`timescale 1ns/1ns

module tb_zport import zport_pkg::*;
();

	localparam int DIR_REQ  = 70;	// directed requests, rounded up
	localparam int RAND_REQ = 200;
	localparam int MAX_CYC  = 4 * (DIR_REQ + RAND_REQ) + 200;

	// address mix for the back-pressure run
	localparam logic [15:0] ADDR_MIX [0:15] = '{16'h00FE, 16'h001F, 16'h7FFD, 16'hFFFD,
		16'h00AF, 16'h10AF, 16'h11AF, 16'h12AF, 16'h13AF, 16'h15AF, 16'h20AF, 16'h21AF,
		16'h25AF, 16'h2AAF, 16'h0033, 16'h12AF};

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic [15:0] req_addr;
	logic [7:0]  req_data;
	logic        req_rnw;
	logic        req_ready;
	logic        rsp_valid;
	logic [7:0]  rsp_data;
	logic        rsp_hit;
	logic        rsp_ready;
	logic        opfetch;
	logic [7:0]  fetch_data;
	logic [4:0]  keys_in;
	logic        tape_in;
	logic [4:0]  kj_in;
	logic [31:0] xt_page;
	logic [7:0]  memconf;
	logic [7:0]  sysconf;
	logic [7:0]  intmask;
	logic [4:0]  fmaddr;
	logic [2:0]  im2v_frm;
	logic [2:0]  im2v_lin;
	logic [2:0]  im2v_dma;

	// reference model state
	logic [7:0]  m_page [0:3];
	logic [7:0]  m_memconf;
	logic [7:0]  m_sysconf;
	logic [7:0]  m_intmask;
	logic [4:0]  m_fmaddr;
	logic [2:0]  m_frm;
	logic [2:0]  m_lin;
	logic [2:0]  m_dma;
	logic        m_lock48;
	logic        m_fetch_lock;
	logic        m_pwr;

	logic [31:0] lfsr = 32'hdb2d8c52;
	logic [24:0] expq [$];	// {addr, hit, data} in request order
	logic        rand_ready = 1'b0;
	int          data_errs = 0;
	int          reg_errs = 0;
	int          flow_errs = 0;
	int          n_req = 0;
	int          n_rsp = 0;
	int          cycles = 0;

	zport_top UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// expected {hit, data}, applies write effects in request order
	function automatic logic [8:0] predict(input logic [15:0] addr, input logic [7:0] data,
		input logic rnw);
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] rd;
		logic       hit;
		logic       lock128;
		p7ffd_u     p;
		lo = addr[7:0];
		hi = addr[15:8];
		rd = 8'hFF;
		hit = 1'b1;
		p.raw = data;
		if (lo == 8'hFE)
		begin
			if (rnw)
				rd = {1'b1, tape_in, 1'b0, keys_in};
		end
		else if (lo == 8'h1F)
		begin
			if (rnw)
				rd = {3'b000, kj_in};
		end
		else if (lo == 8'hFD && !addr[15])
		begin
			if (!rnw && !m_lock48)
			begin
				m_memconf[0] = p.f.rom;
				if (m_memconf[7:6] == 2'b11)
					m_page[3] = {2'b00, p.f.ext, p.f.page_hi, p.f.page_lo};	// 1M map
				else
				begin
					lock128 = (m_memconf[7:6] == 2'b10) ? m_fetch_lock : m_memconf[6];
					m_page[3] = {3'b000, lock128 ? 2'b00 : p.f.page_hi, p.f.page_lo};
					m_lock48 = p.f.ext;
				end
			end
		end
		else if (lo == 8'hAF)
		begin
			if (rnw)
			begin
				if (hi == 8'h00)
				begin
					rd = {1'b0, m_pwr, 6'b000000};
					m_pwr = 1'b0;
				end
				else if (hi == 8'h12)
					rd = m_page[2];
				else if (hi == 8'h13)
					rd = m_page[3];
			end
			else if (hi >= 8'h10 && hi <= 8'h13)
				m_page[hi[1:0]] = data;
			else if (hi == 8'h15)
				m_fmaddr = data[4:0];
			else if (hi == 8'h20)
				m_sysconf = data;
			else if (hi == 8'h21)
				m_memconf = data;
			else if (hi == 8'h2A)
				m_intmask = data;
			else if (hi == 8'h25)
			begin
				if (data[6:4] == 3'd0)
					m_frm = data[3:1];
				else if (data[6:4] == 3'd1)
					m_lin = data[3:1];
				else if (data[6:4] == 3'd2)
					m_dma = data[3:1];
			end
		end
		else
			hit = 1'b0;
		return {hit, rd};
	endfunction

	task automatic compare_reg(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
		else
		begin
			reg_errs++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_regs();
		compare_reg("xt_page", xt_page, {m_page[3], m_page[2], m_page[1], m_page[0]});
		compare_reg("memconf", 32'(memconf), 32'(m_memconf));
		compare_reg("sysconf", 32'(sysconf), 32'(m_sysconf));
		compare_reg("intmask", 32'(intmask), 32'(m_intmask));
		compare_reg("fmaddr", 32'(fmaddr), 32'(m_fmaddr));
		compare_reg("im2v_frm", 32'(im2v_frm), 32'(m_frm));
		compare_reg("im2v_lin", 32'(im2v_lin), 32'(m_lin));
		compare_reg("im2v_dma", 32'(im2v_dma), 32'(m_dma));
	endtask

	task automatic check_response();
		logic [24:0] e;
		if (expq.size() == 0)
		begin
			flow_errs++;
			$display("response arrived at %0t with no request outstanding", $time);
		end
		else
		begin
			e = expq.pop_front();
			n_rsp++;
			assert (rsp_data === e[7:0] && rsp_hit === e[8])
			else
			begin
				data_errs++;
				$display("** Error at %0t: port %h gave %h hit %b, expected %h hit %b",
					$time, e[24:9], rsp_data, rsp_hit, e[7:0], e[8]);
			end
		end
	endtask

	// holds the request until accepted, checks that a stall has a cause
	task automatic send(input logic [15:0] addr, input logic [7:0] data, input logic rnw);
		logic done;
		done = 1'b0;
		@(negedge clk);
		req_valid = 1'b1;
		req_addr = addr;
		req_data = data;
		req_rnw = rnw;
		while (!done)
		begin
			#1;
			if (req_ready)
			begin
				expq.push_back({addr, predict(addr, data, rnw)});
				n_req++;
				done = 1'b1;
			end
			else
			begin
				assert (rsp_valid && !rsp_ready)
				else
				begin
					flow_errs++;
					$display("** Error at %0t: req_ready low with no response stall", $time);
				end
				@(negedge clk);
			end
		end
	endtask

	task automatic drain();
		@(negedge clk);
		req_valid = 1'b0;
		while (expq.size() != 0)
			@(negedge clk);
		@(negedge clk);	// last transfer done
	endtask

	task automatic snoop_fetch(input logic [7:0] d);
		@(negedge clk);
		opfetch = 1'b1;
		fetch_data = d;
		@(negedge clk);
		opfetch = 1'b0;
		m_fetch_lock = !(d[7] ^ d[6]);
	endtask

	task automatic new_inputs();
		logic [31:0] r;
		r = take_bits(11);
		keys_in = r[4:0];
		tape_in = r[5];
		kj_in = r[10:6];
	endtask

	// memconf mode, then two #7FFD writes that leave lock48 alone
	task automatic fd_writes(input logic [7:0] mc);
		logic [31:0] r;
		send(16'h21AF, mc, 1'b0);
		r = take_bits(8);
		send(16'h7FFD, r[7:0] & 8'hDF, 1'b0);
		r = take_bits(8);
		send(16'h7FFD, r[7:0] & 8'hDF, 1'b0);
		send(16'h13AF, 8'h00, 1'b1);
		drain();
		check_regs();
	endtask

	// response side, random rsp_ready only in the back-pressure run
	initial
	begin
		logic [31:0] r;
		rsp_ready = 1'b1;
		wait (rst === 1'b0);
		forever
		begin
			@(negedge clk);
			if (rand_ready)
			begin
				r = take_bits(1);
				rsp_ready = r[0];
			end
			else
				rsp_ready = 1'b1;
			#1;
			if (rsp_valid && rsp_ready)
				check_response();
		end
	end

	initial
	begin
		while (cycles < MAX_CYC)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYC);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		int k;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		req_data = '0;
		req_rnw = 1'b1;
		opfetch = 1'b0;
		fetch_data = '0;
		keys_in = 5'h1F;
		tape_in = 1'b0;
		kj_in = '0;
		m_page[0] = 8'h00;
		m_page[1] = 8'h05;
		m_page[2] = 8'h02;
		m_page[3] = 8'h00;
		m_memconf = 8'h04;
		m_sysconf = 8'h01;
		m_intmask = 8'h01;
		m_fmaddr = '0;
		m_frm = 3'b111;
		m_lin = 3'b111;
		m_dma = 3'b111;
		m_lock48 = 1'b0;
		m_fetch_lock = 1'b0;
		m_pwr = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		assert (req_ready && !rsp_valid)
		else
		begin
			flow_errs++;
			$display("** Error at %0t: handshake not idle after reset", $time);
		end
		check_regs();

		// power-up flag, first read sees it set
		send(16'h00AF, 8'h00, 1'b1);
		send(16'h00AF, 8'h00, 1'b1);
		drain();

		repeat (3)
		begin
			new_inputs();
			send(16'h00FE, 8'h00, 1'b1);
			send(16'h001F, 8'h00, 1'b1);
			send(16'hFFFD, 8'h00, 1'b1);	// a15 set, not #7FFD
			send(16'h0033, 8'h00, 1'b1);
			send(16'h14AF, 8'h00, 1'b1);
			send(16'h00FE, 8'h5A, 1'b0);
			drain();
		end

		for (k = 0; k < 4; k++)
		begin
			r = take_bits(8);
			send({6'b000100, k[1:0], 8'hAF}, r[7:0], 1'b0);
		end
		r = take_bits(24);
		send(16'h15AF, r[7:0], 1'b0);
		send(16'h20AF, r[15:8], 1'b0);
		send(16'h2AAF, r[23:16], 1'b0);
		r = take_bits(9);
		send(16'h25AF, {1'b0, 3'b000, r[2:0], 1'b0}, 1'b0);
		send(16'h25AF, {1'b0, 3'b001, r[5:3], 1'b0}, 1'b0);
		send(16'h25AF, {1'b0, 3'b010, r[8:6], 1'b0}, 1'b0);
		send(16'h25AF, 8'h5E, 1'b0);	// unknown source, no effect
		r = take_bits(16);
		send(16'h12AF, r[7:0], 1'b0);
		send(16'h12AF, 8'h00, 1'b1);	// read right behind its write
		send(16'h13AF, r[15:8], 1'b0);
		send(16'h13AF, 8'h00, 1'b1);
		drain();
		check_regs();

		// #7FFD paging per mode
		fd_writes(8'h04);
		fd_writes(8'h44);
		snoop_fetch(8'h40);	// unlocks
		fd_writes(8'h84);
		snoop_fetch(8'h00);	// locks
		fd_writes(8'h84);
		fd_writes(8'hC4);
		r = take_bits(16);
		send(16'h7FFD, r[7:0] | 8'h20, 1'b0);
		send(16'h7FFD, r[15:8] | 8'h20, 1'b0);
		drain();
		check_regs();

		// lock48 freezes further paging
		fd_writes(8'h04);
		r = take_bits(24);
		send(16'h7FFD, r[7:0] | 8'h20, 1'b0);
		send(16'h7FFD, r[15:8] & 8'hDF, 1'b0);
		send(16'h7FFD, r[23:16] & 8'hDF, 1'b0);
		send(16'h13AF, 8'h00, 1'b1);
		drain();
		check_regs();

		// back-to-back requests under random back-pressure
		new_inputs();
		@(negedge clk);
		#2;
		rand_ready = 1'b1;
		repeat (RAND_REQ)
		begin
			r = take_bits(13);
			send(ADDR_MIX[r[3:0]], r[11:4], r[12]);
		end
		drain();
		#2;
		rand_ready = 1'b0;
		check_regs();
		assert (!rsp_valid && req_ready)
		else
		begin
			flow_errs++;
			$display("pipeline not idle after %0d requests and %0d responses", n_req, n_rsp);
		end

		$display("errors: response %0d, register %0d, handshake %0d",
			data_errs, reg_errs, flow_errs);
		if (data_errs + reg_errs + flow_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* compile.f */
design/zport_pkg.sv
design/port_decode.sv
design/mem_paging.sv
design/sys_regs.sv
design/port_respond.sv
design/zport_top.sv
tests/tb_zport.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the zport testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_zport -f compile.f -o tb_zport
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_zport > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
exit 1
